/* issue_arbiter.sv */
// Round-robin issue merge
`timescale 1ns/1ns
`include "scb_cfg.svh"

module issue_arbiter (
    input  logic            clk,
    input  logic            reset,
    instr_stream_if.slave   slot_in [`SCB_ISSUE_WIDTH],
    output logic            out_valid,
    output scb_pkg::instr_t out_data,
    input  logic            out_ready
);
    localparam int N         = `SCB_ISSUE_WIDTH;
    localparam int SLOT_BITS = `SCB_WID_BITS - `SCB_WIS_BITS;

    logic [N-1:0]         slot_valid;
    scb_pkg::instr_t      slot_data [N];
    logic [SLOT_BITS-1:0] last_grant;
    logic [SLOT_BITS-1:0] grant;
    logic [SLOT_BITS-1:0] cand;
    logic                 grant_valid;

    generate
        for (genvar i = 0; i < N; i++) begin : g_slot
            assign slot_valid[i]   = slot_in[i].valid;
            assign slot_data[i]    = slot_in[i].data;
            assign slot_in[i].ready = out_ready && grant_valid && (grant == SLOT_BITS'(i));
        end
    endgenerate

    // Scan farthest first, so the slot right after the last winner ends up chosen
    always_comb begin
        grant       = last_grant;
        grant_valid = 1'b0;
        cand        = last_grant;
        for (int k = N; k >= 1; k--) begin
            cand = SLOT_BITS'((int'(last_grant) + k) % N);
            if (slot_valid[cand]) begin
                grant       = cand;
                grant_valid = 1'b1;
            end
        end
    end

    // Full warp id from the slot's upper bits and the slot number
    always_comb begin
        out_data     = slot_data[grant];
        out_data.wid = {slot_data[grant].wid[`SCB_WID_BITS-1 -: `SCB_WIS_BITS], grant};
    end

    assign out_valid = grant_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= SLOT_BITS'(N - 1);
        end else if (out_valid && out_ready) begin
            last_grant <= grant;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the scoreboard testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f scb_top.f --top-module scb_tb \
    -o scb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/scb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

/* scb_cfg.svh */
// Scoreboard configuration
`ifndef SCB_CFG_SVH
`define SCB_CFG_SVH

// Slot and warp counts
`define SCB_ISSUE_WIDTH 2
`define SCB_NUM_WARPS   8

// Warp index within a slot, log2(warps / slots)
`define SCB_WIS_BITS    2
`define SCB_WID_BITS    3

// Architectural registers per warp
`define SCB_NUM_REGS    32
`define SCB_REG_BITS    5

// Instruction tag
`define SCB_UUID_BITS   8

// Longest allowed head stall in cycles
`define SCB_STALL_LIMIT 200

`endif

/* scb_checker.sv */
// Scoreboard slot assertions
`timescale 1ns/1ns
`include "scb_cfg.svh"

module scb_checker (
    input logic                                           clk,
    input logic                                           reset,
    input logic                                           wb_fire,
    input scb_pkg::wb_t                                   wb_data,
    input logic [`SCB_WIS_BITS-1:0]                       wb_wis,
    input logic [`SCB_NUM_WARPS/`SCB_ISSUE_WIDTH-1:0][`SCB_NUM_REGS-1:0] inuse_regs,
    input logic                                           head_valid,
    input logic                                           head_ready,
    input logic                                           issue_valid,
    input logic                                           issue_ready,
    input scb_pkg::instr_t                                issue_data
);
    int stall_cycles;

    // Consecutive cycles the head waits
    always_ff @(posedge clk) begin
        if (reset || !head_valid || head_ready) begin
            stall_cycles <= 0;
        end else begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    // Tensor writebacks share one bit per warp, so only register writebacks are checked
    wb_targets_busy: assert property (@(posedge clk) disable iff (reset)
        (wb_fire && !wb_data.tensor) |-> inuse_regs[wb_wis][wb_data.rd])
        else $error("writeback to a register that is not busy");

    head_stall_bounded: assert property (@(posedge clk) disable iff (reset)
        stall_cycles < `SCB_STALL_LIMIT)
        else $error("slot head stalled beyond the limit");

    issue_held: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_data)))
        else $error("issue valid or data changed before ready");

endmodule

bind warp_scoreboard scb_checker checker_i (
    .clk          (clk),
    .reset        (reset),
    .wb_fire      (wb_fire),
    .wb_data      (wb.data),
    .wb_wis       (wb_wis),
    .inuse_regs   (inuse_regs),
    .head_valid   (ibuf.valid),
    .head_ready   (ibuf.ready),
    .issue_valid  (issue.valid),
    .issue_ready  (issue.ready),
    .issue_data   (issue.data)
);

/* scb_ifs.sv */
// Scoreboard stream interfaces
`timescale 1ns/1ns

// Instruction stream with valid/ready handshake
interface instr_stream_if;
    logic            valid;
    logic            ready;
    scb_pkg::instr_t data;

    modport master (
        output valid,
        output data,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        output ready
    );
endinterface

// Writeback stream, never back-pressured
interface wb_if;
    logic         valid;
    scb_pkg::wb_t data;

    modport master (output valid, output data);
    modport slave (input valid, input data);
endinterface

/* scb_monitor.sv */
// Scoreboard output monitor
`timescale 1ns/1ns
`include "scb_cfg.svh"

module scb_monitor (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic            in_ready,
    input  scb_pkg::instr_t in_data,
    input  logic            wb_valid,
    input  scb_pkg::wb_t    wb_data,
    input  logic            out_valid,
    input  logic            out_ready,
    input  scb_pkg::instr_t out_data,
    input  logic [95:0]     test_name,
    output int              errors,
    output int              pending
);
    logic [`SCB_NUM_REGS-1:0] busy [`SCB_NUM_WARPS];
    logic                     tbusy [`SCB_NUM_WARPS];
    scb_pkg::instr_t          exp_q [`SCB_NUM_WARPS][$];
    int                       err_cnt;
    int                       pend_cnt;

    // Reference rule: may this instruction leave the input now
    function automatic logic may_issue(scb_pkg::instr_t ins, logic [`SCB_NUM_REGS-1:0] regs,
                                       logic tbit);
        logic reg_hazard;
        reg_hazard = regs[ins.rd] || regs[ins.rs1] || regs[ins.rs2] || regs[ins.rs3];
        return !reg_hazard && !(ins.tensor_wait && tbit);
    endfunction

    initial begin
        errors  <= 0;
        pending <= 0;
    end

    always @(posedge clk) begin : watch
        scb_pkg::instr_t exp;
        if (reset) begin
            for (int w = 0; w < `SCB_NUM_WARPS; w++) begin
                busy[w]  = '0;
                tbusy[w] = 1'b0;
                exp_q[w].delete();
            end
            err_cnt  = 0;
            pend_cnt = 0;
        end else begin
            if (in_valid && in_ready) begin
                if (!may_issue(in_data, busy[in_data.wid], tbusy[in_data.wid])) begin
                    $display("Hazard missed in %0s: uuid %0d of warp %0d accepted while busy",
                             test_name, in_data.uuid, in_data.wid);
                    err_cnt++;
                end
                exp_q[in_data.wid].push_back(in_data);
                pend_cnt++;
            end
            // Clear before set, as in the slot
            if (wb_valid && wb_data.eop) begin
                if (wb_data.tensor) begin
                    tbusy[wb_data.wid] = 1'b0;
                end else begin
                    busy[wb_data.wid][wb_data.rd] = 1'b0;
                end
            end
            if (in_valid && in_ready) begin
                if (in_data.wb) begin
                    busy[in_data.wid][in_data.rd] = 1'b1;
                end
                if (in_data.ex_type == scb_pkg::EX_TENSOR) begin
                    tbusy[in_data.wid] = 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q[out_data.wid].size() == 0) begin
                    $display("Unexpected output in %0s: uuid %0d of warp %0d was never sent",
                             test_name, out_data.uuid, out_data.wid);
                    err_cnt++;
                end else begin
                    exp = exp_q[out_data.wid].pop_front();
                    pend_cnt--;
                    if (exp !== out_data) begin
                        $display("CHECK FAILED %0s: expected %h actual %h",
                                 test_name, exp, out_data);
                        err_cnt++;
                    end
                end
            end
        end
        errors  <= err_cnt;
        pending <= pend_cnt;
    end

endmodule

/* scb_pkg.sv */
// Scoreboard shared types
`include "scb_cfg.svh"

package scb_pkg;

    // Execution unit class
    typedef enum logic [1:0] {
        EX_ALU    = 2'd0,
        EX_LSU    = 2'd1,
        EX_SFU    = 2'd2,
        EX_TENSOR = 2'd3
    } ex_type_e;

    // Decoded instruction as seen by the issue stage
    typedef struct packed {
        logic [`SCB_UUID_BITS-1:0] uuid;
        logic [`SCB_WID_BITS-1:0]  wid;
        ex_type_e                  ex_type;
        logic                      wb;
        logic                      tensor_wait;
        logic [`SCB_REG_BITS-1:0]  rd;
        logic [`SCB_REG_BITS-1:0]  rs1;
        logic [`SCB_REG_BITS-1:0]  rs2;
        logic [`SCB_REG_BITS-1:0]  rs3;
    } instr_t;

    // Writeback returned by an execution unit
    typedef struct packed {
        logic [`SCB_WID_BITS-1:0] wid;
        logic [`SCB_REG_BITS-1:0] rd;
        logic                     eop;
        logic                     tensor;
    } wb_t;

endpackage

/* scb_tb.sv */
// Scoreboard testbench top
`timescale 1ns/1ns
`include "scb_cfg.svh"

module scb_tb;
    localparam int TOTAL_INSTR = 424;
    localparam int CYCLE_LIMIT = TOTAL_INSTR * `SCB_STALL_LIMIT;

    logic            clk;
    logic            reset;
    logic            in_valid;
    scb_pkg::instr_t in_data;
    logic            in_ready;
    logic            wb_valid;
    scb_pkg::wb_t    wb_data;
    logic            out_valid;
    scb_pkg::instr_t out_data;
    logic            out_ready;

    logic            bp_mode;
    logic [95:0]     test_name;
    int              errors;
    int              pending;
    int              cycles;
    int              tests_run;
    int              tests_failed;
    int              err_before;
    int              uuid_next;
    scb_pkg::wb_t    wb_q [$];
    int              due_q [$];

    tb_clock clock_gen (.clk(clk));

    scb_top scb_top_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    scb_monitor monitor (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .test_name (test_name),
        .errors    (errors),
        .pending   (pending)
    );

    // Cycle counter and hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Output back-pressure
    always @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= bp_mode ? 1'($urandom) : 1'b1;
        end
    end

    // Execution units return writebacks after a random delay
    always @(posedge clk) begin : wb_model
        scb_pkg::wb_t w;
        logic sent;
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready &&
                (out_data.wb || out_data.ex_type == scb_pkg::EX_TENSOR)) begin
                w.wid    = out_data.wid;
                w.rd     = out_data.rd;
                w.eop    = 1'b1;
                w.tensor = (out_data.ex_type == scb_pkg::EX_TENSOR);
                wb_q.push_back(w);
                due_q.push_back(cycles + 1 + int'($urandom % 6));
            end
            wb_valid <= 1'b0;
            sent = 1'b0;
            for (int i = 0; i < wb_q.size(); i++) begin
                if (!sent && due_q[i] <= cycles) begin
                    wb_valid <= 1'b1;
                    wb_data  <= wb_q[i];
                    wb_q.delete(i);
                    due_q.delete(i);
                    sent = 1'b1;
                end
            end
        end
    end

    task automatic send(input logic [2:0] wid, input scb_pkg::ex_type_e ex, input logic wb,
                        input logic tw, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [4:0] rs3);
        scb_pkg::instr_t ins;
        ins.uuid        = 8'(uuid_next);
        ins.wid         = wid;
        ins.ex_type     = ex;
        ins.wb          = wb;
        ins.tensor_wait = tw;
        ins.rd          = rd;
        ins.rs1         = rs1;
        ins.rs2         = rs2;
        ins.rs3         = rs3;
        uuid_next++;
        in_valid <= 1'b1;
        in_data  <= ins;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic send_random();
        scb_pkg::ex_type_e ex;
        ex = scb_pkg::ex_type_e'(2'($urandom));
        send(3'($urandom), ex, (ex != scb_pkg::EX_TENSOR) && 1'($urandom),
             ($urandom % 4) == 0, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom));
    endtask

    task automatic start_test(input logic [95:0] name);
        test_name  <= name;
        err_before = errors;
    endtask

    // Drain outputs and writebacks, then report
    task automatic finish_test();
        @(posedge clk);
        while (pending != 0 || wb_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("%0s: %0d errors", test_name, errors - err_before);
    endtask

    initial begin
        void'($urandom(32'h175f_8c07));
        reset        <= 1'b1;
        in_valid     <= 1'b0;
        in_data      <= '0;
        wb_valid     <= 1'b0;
        wb_data      <= '0;
        out_ready    <= 1'b0;
        bp_mode      <= 1'b0;
        cycles       <= 0;
        tests_run    = 0;
        tests_failed = 0;
        uuid_next    = 0;
        test_name    <= "reset";
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        start_test("independent");
        for (int w = 0; w < `SCB_NUM_WARPS; w++) begin
            send(3'(w), scb_pkg::EX_ALU, 1'b1, 1'b0, 5'(w + 1), 5'd20, 5'd21, 5'd22);
        end
        finish_test();

        start_test("raw_hazard");
        send(3'd0, scb_pkg::EX_LSU, 1'b1, 1'b0, 5'd3, 5'd10, 5'd11, 5'd12);
        send(3'd0, scb_pkg::EX_ALU, 1'b1, 1'b0, 5'd4, 5'd3, 5'd10, 5'd11);
        send(3'd0, scb_pkg::EX_ALU, 1'b1, 1'b0, 5'd6, 5'd10, 5'd4, 5'd11);
        send(3'd0, scb_pkg::EX_ALU, 1'b0, 1'b0, 5'd7, 5'd10, 5'd11, 5'd6);
        finish_test();

        start_test("waw_hazard");
        send(3'd2, scb_pkg::EX_SFU, 1'b1, 1'b0, 5'd9, 5'd1, 5'd2, 5'd3);
        send(3'd2, scb_pkg::EX_ALU, 1'b1, 1'b0, 5'd9, 5'd1, 5'd2, 5'd3);
        send(3'd2, scb_pkg::EX_ALU, 1'b0, 1'b0, 5'd9, 5'd9, 5'd1, 5'd2);
        finish_test();

        // Warp 5 sits in the other slot
        start_test("tensor_wait");
        send(3'd4, scb_pkg::EX_TENSOR, 1'b0, 1'b0, 5'd0, 5'd1, 5'd2, 5'd3);
        send(3'd5, scb_pkg::EX_ALU, 1'b1, 1'b0, 5'd8, 5'd1, 5'd2, 5'd3);
        send(3'd5, scb_pkg::EX_ALU, 1'b1, 1'b0, 5'd12, 5'd1, 5'd2, 5'd3);
        send(3'd4, scb_pkg::EX_ALU, 1'b0, 1'b1, 5'd5, 5'd1, 5'd2, 5'd3);
        send(3'd5, scb_pkg::EX_ALU, 1'b0, 1'b0, 5'd13, 5'd1, 5'd2, 5'd3);
        finish_test();

        start_test("backpressure");
        bp_mode <= 1'b1;
        repeat (40) send_random();
        finish_test();

        start_test("random_mix");
        repeat (300) send_random();
        finish_test();
        bp_mode <= 1'b0;

        // Every register and tensor bit of every warp must read free again
        start_test("busy_clear");
        for (int w = 0; w < `SCB_NUM_WARPS; w++) begin
            for (int r = 0; r < `SCB_NUM_REGS; r += 4) begin
                send(3'(w), scb_pkg::EX_ALU, 1'b0, 1'b1, 5'(r), 5'(r + 1), 5'(r + 2), 5'(r + 3));
            end
        end
        finish_test();

        $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* scb_top.f */
+incdir+.
scb_pkg.sv
scb_ifs.sv
warp_dispatch.sv
stream_buffer.sv
warp_scoreboard.sv
issue_arbiter.sv
scb_top.sv
tb_clock.sv
scb_checker.sv
scb_monitor.sv
scb_tb.sv

/* scb_top.sv */
// Issue-stage scoreboard top
`timescale 1ns/1ns
`include "scb_cfg.svh"

module scb_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  scb_pkg::instr_t in_data,
    output logic            in_ready,
    input  logic            wb_valid,
    input  scb_pkg::wb_t    wb_data,
    output logic            out_valid,
    output scb_pkg::instr_t out_data,
    input  logic            out_ready
);
    instr_stream_if disp_if [`SCB_ISSUE_WIDTH] ();
    wb_if           slot_wb_if [`SCB_ISSUE_WIDTH] ();
    instr_stream_if issue_if [`SCB_ISSUE_WIDTH] ();

    warp_dispatch dispatch (
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .slot_out (disp_if),
        .slot_wb  (slot_wb_if)
    );

    generate
        for (genvar i = 0; i < `SCB_ISSUE_WIDTH; i++) begin : g_slot
            warp_scoreboard scoreboard (
                .clk   (clk),
                .reset (reset),
                .ibuf  (disp_if[i]),
                .wb    (slot_wb_if[i]),
                .issue (issue_if[i])
            );
        end
    endgenerate

    issue_arbiter arbiter (
        .clk       (clk),
        .reset     (reset),
        .slot_in   (issue_if),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

/* stream_buffer.sv */
// Two-entry stream buffer
`timescale 1ns/1ns

module stream_buffer (
    input  logic            clk,
    input  logic            reset,
    input  logic            valid_in,
    input  scb_pkg::instr_t data_in,
    output logic            ready_in,
    output logic            valid_out,
    output scb_pkg::instr_t data_out,
    input  logic            ready_out
);
    scb_pkg::instr_t skid_data;
    logic            skid_valid;
    logic            skid_valid_n;
    logic            load_out;
    logic            push;

    assign load_out = !valid_out || ready_out;
    assign push     = valid_in && ready_in;

    // Skid entry fills only when the output register is stuck
    assign skid_valid_n = skid_valid ? !load_out : (push && !load_out);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
            ready_in   <= 1'b0;
        end else begin
            valid_out  <= load_out ? (skid_valid || push) : valid_out;
            skid_valid <= skid_valid_n;
            ready_in   <= !skid_valid_n;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (load_out) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (push && !load_out) begin
            skid_data <= data_in;
        end
    end

endmodule

/* tb_clock.sv */
// Testbench clock source
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

/* warp_dispatch.sv */
// Warp to slot dispatch
`timescale 1ns/1ns
`include "scb_cfg.svh"

module warp_dispatch (
    input  logic            in_valid,
    input  scb_pkg::instr_t in_data,
    output logic            in_ready,
    input  logic            wb_valid,
    input  scb_pkg::wb_t    wb_data,
    instr_stream_if.master  slot_out [`SCB_ISSUE_WIDTH],
    wb_if.master            slot_wb [`SCB_ISSUE_WIDTH]
);
    localparam int SLOT_BITS = `SCB_WID_BITS - `SCB_WIS_BITS;

    logic [SLOT_BITS-1:0]        in_sel;
    logic [SLOT_BITS-1:0]        wb_sel;
    logic [`SCB_ISSUE_WIDTH-1:0] slot_ready;

    // Owning slot sits in the low warp id bits
    assign in_sel = in_data.wid[SLOT_BITS-1:0];
    assign wb_sel = wb_data.wid[SLOT_BITS-1:0];

    generate
        for (genvar i = 0; i < `SCB_ISSUE_WIDTH; i++) begin : g_slot
            // Instruction path
            assign slot_out[i].valid = in_valid && (in_sel == SLOT_BITS'(i));
            assign slot_out[i].data  = in_data;
            assign slot_ready[i]     = slot_out[i].ready;

            // Writeback path
            assign slot_wb[i].valid = wb_valid && (wb_sel == SLOT_BITS'(i));
            assign slot_wb[i].data  = wb_data;
        end
    endgenerate

    // Only the addressed slot can accept
    assign in_ready = slot_ready[in_sel];

endmodule

/* warp_scoreboard.sv */
// Per-slot register scoreboard
`timescale 1ns/1ns
`include "scb_cfg.svh"

module warp_scoreboard (
    input  logic           clk,
    input  logic           reset,
    instr_stream_if.slave  ibuf,
    wb_if.slave            wb,
    instr_stream_if.master issue
);
    localparam int WARPS_PER_SLOT = `SCB_NUM_WARPS / `SCB_ISSUE_WIDTH;

    // One bit per register of each warp served here
    logic [WARPS_PER_SLOT-1:0][`SCB_NUM_REGS-1:0] inuse_regs;
    // Tensor unit has no destination register
    logic [WARPS_PER_SLOT-1:0]                    inuse_tensor;

    logic [`SCB_WIS_BITS-1:0] head_wis;
    logic [`SCB_WIS_BITS-1:0] wb_wis;

    logic       inuse_rd;
    logic       inuse_rs1;
    logic       inuse_rs2;
    logic       inuse_rs3;
    logic       tensor_block;
    logic [3:0] operands_busy;
    logic       operands_ready;

    logic       stg_valid;
    logic       stg_ready;
    logic       accept;
    logic       wb_fire;

    // Within-slot index from the upper warp id bits
    assign head_wis = ibuf.data.wid[`SCB_WID_BITS-1 -: `SCB_WIS_BITS];
    assign wb_wis   = wb.data.wid[`SCB_WID_BITS-1 -: `SCB_WIS_BITS];

    // Hazard lookup for the head instruction
    assign inuse_rd  = inuse_regs[head_wis][ibuf.data.rd];
    assign inuse_rs1 = inuse_regs[head_wis][ibuf.data.rs1];
    assign inuse_rs2 = inuse_regs[head_wis][ibuf.data.rs2];
    assign inuse_rs3 = inuse_regs[head_wis][ibuf.data.rs3];

    // rd is checked too, which blocks WAW
    assign operands_busy  = {inuse_rd, inuse_rs1, inuse_rs2, inuse_rs3};
    assign tensor_block   = ibuf.data.tensor_wait && inuse_tensor[head_wis];
    assign operands_ready = !(|operands_busy) && !tensor_block;

    assign stg_valid  = ibuf.valid && operands_ready;
    assign ibuf.ready = stg_ready && operands_ready;

    assign accept  = ibuf.valid && ibuf.ready;
    assign wb_fire = wb.valid && wb.data.eop;

    stream_buffer staging (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (stg_valid),
        .data_in   (ibuf.data),
        .ready_in  (stg_ready),
        .valid_out (issue.valid),
        .data_out  (issue.data),
        .ready_out (issue.ready)
    );

    // Clears come first so a set on the same edge wins
    always_ff @(posedge clk) begin
        if (reset) begin
            inuse_regs   <= '0;
            inuse_tensor <= '0;
        end else begin
            if (wb_fire) begin
                if (wb.data.tensor) begin
                    inuse_tensor[wb_wis] <= 1'b0;
                end else begin
                    inuse_regs[wb_wis][wb.data.rd] <= 1'b0;
                end
            end
            if (accept && ibuf.data.wb) begin
                inuse_regs[head_wis][ibuf.data.rd] <= 1'b1;
            end
            if (accept && (ibuf.data.ex_type == scb_pkg::EX_TENSOR)) begin
                inuse_tensor[head_wis] <= 1'b1;
            end
        end
    end

endmodule
